//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_fetch
FILELIST   := src.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hdl/fetch_cfg_regs.sv
`timescale 1ns/1ns
`include "fetch_config.svh"

module fetch_cfg_regs
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cfg_we,
    input  cfg_reg_e    cfg_addr,
    input  logic [31:0] cfg_wdata,
    output fetch_cfg_t  cfg,
    output logic        start_valid,
    output logic [31:0] start_pc
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg.boot_pc     <= `BOOT_PC_RST;
            cfg.burst_base  <= `BURST_BASE_RST;
            cfg.burst_end   <= `BURST_END_RST;
            cfg.enable      <= 1'b0;
            start_valid     <= 1'b0;
        end else begin
            start_valid <= 1'b0;
            if (cfg_we) begin
                case (cfg_addr)
                    CFG_BOOT_PC: begin
                        cfg.boot_pc <= cfg_wdata;
                        start_valid <= 1'b1; // a new boot pc restarts fetch there
                    end
                    CFG_BURST_BASE: cfg.burst_base <= cfg_wdata;
                    CFG_BURST_END:  cfg.burst_end  <= cfg_wdata;
                    CFG_ENABLE:     cfg.enable     <= cfg_wdata[0];
                endcase
            end
        end
    end

    // the pulse comes a cycle after the write, so the register already holds the target
    assign start_pc = cfg.boot_pc;

    // an inverted burst window would silently turn every refill into single beats
    assert property (@(posedge clk) disable iff (rst)
        cfg.enable |-> cfg.burst_base <= cfg.burst_end)
        else $error("burst region is inverted while fetch is enabled");

endmodule

//--- hdl/fetch_pkg.sv
package fetch_pkg;

    // AXI encodings used by the refill path
    localparam logic [1:0] BURST_FIXED = 2'b00;
    localparam logic [1:0] BURST_INCR  = 2'b01;
    localparam logic [1:0] RESP_OKAY   = 2'b00;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        fault; // set when the line could not be read
    } fetch_pkt_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } ar_req_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
    } r_beat_t;

    typedef struct packed {
        logic [31:0] boot_pc;
        logic [31:0] burst_base;
        logic [31:0] burst_end; // inclusive upper bound
        logic        enable;
    } fetch_cfg_t;

    typedef enum logic [1:0] {
        CFG_BOOT_PC,
        CFG_BURST_BASE,
        CFG_BURST_END,
        CFG_ENABLE
    } cfg_reg_e;

endpackage

//--- hdl/fetch_top.sv
`timescale 1ns/1ns
`include "fetch_config.svh"

module fetch_top
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cfg_we,
    input  cfg_reg_e    cfg_addr,
    input  logic [31:0] cfg_wdata,
    input  logic        redirect_valid,
    input  logic [31:0] redirect_pc,
    output logic        pkt_valid,
    output fetch_pkt_t  pkt,
    input  logic        credit_return,
    output logic        arvalid,
    input  logic        arready,
    output ar_req_t     ar,
    input  logic        rvalid,
    output logic        rready,
    input  r_beat_t     r
);

    fetch_cfg_t               cfg;
    logic                     start_valid;
    logic [31:0]              start_pc;
    logic [31:0]              cache_pc;
    logic                     hit;
    logic [31:0]              hit_inst;
    logic                     fill_valid;
    logic [31:0]              fill_pc;
    logic [`LINE_BYTES*8-1:0] fill_line;

    fetch_cfg_regs i_cfg (
        .clk, .rst, .cfg_we, .cfg_addr, .cfg_wdata, .cfg, .start_valid, .start_pc
    );

    fetch_unit i_fetch (
        .clk, .rst, .cfg, .start_valid, .start_pc, .redirect_valid, .redirect_pc,
        .credit_return, .pkt_valid, .pkt, .cache_pc, .hit, .hit_inst,
        .fill_valid, .fill_pc, .fill_line,
        .arvalid, .arready, .ar, .rvalid, .rready, .r
    );

    icache i_icache (
        .clk, .rst, .pc(cache_pc), .hit, .hit_inst, .fill_valid, .fill_pc, .fill_line
    );

endmodule

//--- hdl/fetch_unit.sv
`timescale 1ns/1ns
`include "fetch_config.svh"

module fetch_unit
    import fetch_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  fetch_cfg_t               cfg,
    input  logic                     start_valid,
    input  logic [31:0]              start_pc,
    input  logic                     redirect_valid,
    input  logic [31:0]              redirect_pc,
    input  logic                     credit_return,
    output logic                     pkt_valid,
    output fetch_pkt_t               pkt,
    output logic [31:0]              cache_pc,
    input  logic                     hit,
    input  logic [31:0]              hit_inst,
    output logic                     fill_valid,
    output logic [31:0]              fill_pc,
    output logic [`LINE_BYTES*8-1:0] fill_line,
    output logic                     arvalid,
    input  logic                     arready,
    output ar_req_t                  ar,
    input  logic                     rvalid,
    output logic                     rready,
    input  r_beat_t                  r
);

    localparam int OFFSET_W = $clog2(`LINE_BYTES);
    localparam int BEAT_W   = $clog2(`LINE_WORDS);
    localparam int CREDIT_W = $clog2(`FETCH_CREDITS + 1);

    typedef enum logic [1:0] {S_IDLE, S_REQ, S_RECV, S_FAULT} state_e;

    state_e                   state;
    logic [31:0]              pc;
    logic [CREDIT_W-1:0]      credits;
    logic [BEAT_W-1:0]        beat_cnt;
    logic [`LINE_BYTES*8-1:0] line_buf;
    logic                     burst_mode;
    logic                     r_err;
    logic                     redir_pend;
    logic [31:0]              redir_pc_q;

    logic        take_valid;
    logic [31:0] take_pc;
    logic [31:0] line_base;
    logic        in_burst;
    logic        fetch_ok;
    logic        hit_issue;
    logic        fault_issue;
    logic        issue;
    logic        start_miss;
    logic        beat;
    logic        beat_done;
    logic        line_bad;
    logic        line_last;
    logic        next_single;

    assign take_valid = start_valid || redirect_valid;
    assign take_pc    = start_valid ? start_pc : redirect_pc; // a fresh start wins
    assign line_base  = {pc[31:OFFSET_W], {OFFSET_W{1'b0}}};
    assign in_burst   = (line_base >= cfg.burst_base) && (line_base <= cfg.burst_end);

    // a redirect, new or held back by a refill, takes the idle cycle instead of a lookup
    assign fetch_ok    = (state == S_IDLE) && cfg.enable && !take_valid && !redir_pend;
    assign hit_issue   = fetch_ok && hit && (credits != '0);
    assign fault_issue = (state == S_FAULT) && (credits != '0);
    assign issue       = hit_issue || fault_issue;
    assign start_miss  = fetch_ok && !hit;

    assign beat        = (state == S_RECV) && rvalid && rready;
    assign beat_done   = beat && r.last;
    assign line_bad    = r_err || (r.resp != RESP_OKAY);
    assign line_last   = burst_mode || (beat_cnt == BEAT_W'(`LINE_WORDS - 1));
    assign next_single = beat_done && !line_bad && !line_last;

    assign cache_pc   = pc;
    assign fill_pc    = pc; // pc holds still for the whole refill
    assign fill_valid = beat_done && !line_bad && line_last;

    // the final beat goes straight into the line so the cache fills on that edge
    always_comb begin
        fill_line = line_buf;
        fill_line[beat_cnt*32 +: 32] = r.data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= S_IDLE;
            pc         <= `BOOT_PC_RST;
            credits    <= CREDIT_W'(`FETCH_CREDITS);
            pkt_valid  <= 1'b0;
            arvalid    <= 1'b0;
            rready     <= 1'b0;
            beat_cnt   <= '0;
            burst_mode <= 1'b0;
            r_err      <= 1'b0;
            redir_pend <= 1'b0;
        end else begin
            pkt_valid <= issue;
            credits   <= credits + CREDIT_W'(credit_return) - CREDIT_W'(issue);
            if (issue)
                pc <= pc + 32'd4;
            if (state == S_IDLE) begin
                redir_pend <= 1'b0;
                if (take_valid)
                    pc <= take_pc;
                else if (redir_pend)
                    pc <= redir_pc_q;
            end else if (take_valid) begin
                redir_pend <= 1'b1;     // applied once the refill is over
            end
            case (state)
                S_IDLE: begin
                    if (start_miss) begin
                        state      <= S_REQ;
                        arvalid    <= 1'b1;
                        beat_cnt   <= '0;
                        r_err      <= 1'b0;
                        burst_mode <= in_burst;
                    end
                end
                S_REQ: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                        state   <= S_RECV;
                    end
                end
                S_RECV: begin
                    if (beat) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (r.resp != RESP_OKAY)
                            r_err <= 1'b1; // a burst still drains up to rlast
                    end
                    if (beat_done) begin
                        rready <= 1'b0;
                        if (line_bad) begin
                            state <= S_FAULT;
                        end else if (line_last) begin
                            state <= S_IDLE;
                        end else begin
                            state   <= S_REQ;
                            arvalid <= 1'b1;
                        end
                    end
                end
                S_FAULT: begin
                    if (fault_issue)
                        state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue)
            pkt <= '{pc: pc, inst: fault_issue ? 32'h0 : hit_inst, fault: fault_issue};
        if (start_miss) begin
            ar.addr  <= line_base;
            ar.len   <= in_burst ? 8'(`LINE_WORDS - 1) : 8'd0;
            ar.size  <= 3'd2;
            ar.burst <= in_burst ? BURST_INCR : BURST_FIXED;
        end else if (next_single) begin
            ar.addr <= ar.addr + 32'd4;
        end
        if (beat)
            line_buf[beat_cnt*32 +: 32] <= r.data;
        if (take_valid)
            redir_pc_q <= take_pc;
    end

    // decode must never return more credits than it was given
    assert property (@(posedge clk) disable iff (rst) credits <= CREDIT_W'(`FETCH_CREDITS))
        else $error("credit count above decode buffer depth");

    assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(ar))
        else $error("read request changed before it was accepted");

endmodule

//--- hdl/icache.sv
`timescale 1ns/1ns
`include "fetch_config.svh"

module icache (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [31:0]              pc,
    output logic                     hit,
    output logic [31:0]              hit_inst,
    input  logic                     fill_valid,
    input  logic [31:0]              fill_pc,
    input  logic [`LINE_BYTES*8-1:0] fill_line
);

    localparam int OFFSET_W = $clog2(`LINE_BYTES);
    localparam int INDEX_W  = $clog2(`CACHE_LINES);
    localparam int TAG_W    = 32 - OFFSET_W - INDEX_W;

    logic [TAG_W-1:0]          tag_mem [`CACHE_LINES];
    logic [`LINE_BYTES*8-1:0]  data_mem [`CACHE_LINES];
    logic [`CACHE_LINES-1:0]   valid;

    logic [INDEX_W-1:0]  idx;
    logic [TAG_W-1:0]    tag;
    logic [OFFSET_W-3:0] word;
    logic [INDEX_W-1:0]  fill_idx;
    logic [TAG_W-1:0]    fill_tag;
    logic                fill_hit;

    // pc splits into tag, index and byte offset within the line
    assign idx  = pc[OFFSET_W +: INDEX_W];
    assign tag  = pc[31 -: TAG_W];
    assign word = pc[OFFSET_W-1:2];

    assign fill_idx = fill_pc[OFFSET_W +: INDEX_W];
    assign fill_tag = fill_pc[31 -: TAG_W];

    assign hit      = valid[idx] && (tag_mem[idx] == tag);
    assign hit_inst = data_mem[idx][word*32 +: 32];
    assign fill_hit = valid[fill_idx] && (tag_mem[fill_idx] == fill_tag);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
        end else if (fill_valid) begin
            valid[fill_idx] <= 1'b1;
        end
    end

    // a fill overwrites whatever line sat in this slot before
    always_ff @(posedge clk) begin
        if (fill_valid) begin
            tag_mem[fill_idx]  <= fill_tag;
            data_mem[fill_idx] <= fill_line;
        end
    end

    // fetch only refills on a miss, so a fill of a resident line means the FSM lost track
    assert property (@(posedge clk) disable iff (rst) fill_valid |-> !fill_hit)
        else $error("refill of a line that already hits");

endmodule

//--- include/fetch_config.svh
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// cache geometry, one line is four 32-bit words
`define LINE_BYTES 16
`define LINE_WORDS 4
`define CACHE_LINES 16

// depth of the decode buffer, fetch starts out owning every slot
`define FETCH_CREDITS 2

// configuration register values after reset
`define BOOT_PC_RST 32'h3000_0000
`define BURST_BASE_RST 32'ha000_0000
`define BURST_END_RST 32'hbfff_ffff

`endif

//--- src.f
+incdir+include
hdl/fetch_pkg.sv
hdl/fetch_cfg_regs.sv
hdl/icache.sv
hdl/fetch_unit.sv
hdl/fetch_top.sv
test/tb_axi_mem.sv
test/tb_fetch.sv

//--- test/tb_axi_mem.sv
`timescale 1ns/1ns

module tb_axi_mem
    import fetch_pkg::*;
#(
    parameter logic [31:0] SEED     = 32'hbdfc,
    parameter logic [31:0] ERR_BASE = 32'h0,
    parameter logic [31:0] ERR_END  = 32'h0
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    arvalid,
    output logic    arready,
    input  ar_req_t ar,
    output logic    rvalid,
    input  logic    rready,
    output r_beat_t r
);

    logic [31:0] seed;
    logic        busy;
    logic        incr;
    logic [31:0] addr;
    logic [8:0]  beats_left;
    int          delay;
    logic        ar_hs;
    logic        r_hs;
    ar_req_t     req;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // handshakes are seen on the rising edge, outputs change on the falling edge
    initial begin
        seed = SEED;
        arready = 1'b0;
        rvalid = 1'b0;
        r = '0;
        busy = 1'b0;
        forever begin
            @(posedge clk);
            ar_hs = arvalid && arready;
            r_hs  = rvalid && rready;
            req   = ar;
            @(negedge clk);
            seed = lcg_next(seed);
            if (rst) begin
                arready = 1'b0;
                rvalid = 1'b0;
                busy = 1'b0;
            end else begin
                if (r_hs) begin
                    rvalid = 1'b0;
                    beats_left = beats_left - 9'd1;
                    busy = (beats_left != 9'd0);
                    if (incr)
                        addr = addr + 32'd4;
                    delay = int'(seed[17:16]); // gap before the next beat
                end
                if (ar_hs) begin
                    busy = 1'b1;
                    arready = 1'b0;
                    addr = req.addr;
                    beats_left = req.len + 9'd1;
                    incr = (req.burst == BURST_INCR);
                    delay = int'(seed[19:18]);
                end else if (!busy) begin
                    arready = seed[20];
                end
                if (busy && !rvalid) begin
                    if (delay == 0) begin
                        rvalid = 1'b1;
                        r.data = addr ^ 32'h5a5a_0000;
                        r.resp = (addr >= ERR_BASE && addr <= ERR_END) ? 2'b10 : RESP_OKAY;
                        r.last = (beats_left == 9'd1);
                    end else begin
                        delay--;
                    end
                end
            end
        end
    end

endmodule

//--- test/tb_fetch.sv
`timescale 1ns/1ns
`include "fetch_config.svh"

module tb_fetch
    import fetch_pkg::*;
();

    localparam logic [31:0] BOOT_PC    = 32'h3000_0100;
    localparam logic [31:0] BURST_BASE = 32'ha000_0000;
    localparam logic [31:0] BURST_END  = 32'ha000_ffff;
    localparam logic [31:0] ERR_BASE   = 32'ha000_0400; // one line that answers with SLVERR
    localparam logic [31:0] ERR_END    = 32'ha000_040f;
    localparam int          WAIT_LIMIT = 4000;

    logic        clk = 1'b0;
    logic        rst;
    logic        cfg_we;
    cfg_reg_e    cfg_addr;
    logic [31:0] cfg_wdata;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic        pkt_valid;
    fetch_pkt_t  pkt;
    logic        credit_return;
    logic        arvalid;
    logic        arready;
    ar_req_t     ar;
    logic        rvalid;
    logic        rready;
    r_beat_t     r;

    logic [31:0] rnd;
    int          err_cnt [6];
    int          pkt_total;
    int          returns_done;
    int          return_wait;
    int          outstanding;
    int          idx;
    bit          have_last;
    bit          expect_target;
    bit          target_armed;
    logic [31:0] last_pc;
    logic [31:0] target_pc;
    logic [31:0] armed_pc;
    logic [31:0] last_single;
    logic [31:0] resident_line [`CACHE_LINES];
    bit          resident_ok [`CACHE_LINES];

    fetch_top i_dut (
        .clk, .rst, .cfg_we, .cfg_addr, .cfg_wdata, .redirect_valid, .redirect_pc,
        .pkt_valid, .pkt, .credit_return, .arvalid, .arready, .ar, .rvalid, .rready, .r
    );

    tb_axi_mem #(.SEED(32'hbdfc), .ERR_BASE(ERR_BASE), .ERR_END(ERR_END)) i_mem (
        .clk, .rst, .arvalid, .arready, .ar, .rvalid, .rready, .r
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int cache_index(input logic [31:0] addr);
        return int'((addr / `LINE_BYTES) % `CACHE_LINES);
    endfunction

    // outputs are sampled on the rising edge, a target counts from the cycle after it is taken
    always @(posedge clk) begin
        if (!rst) begin
            if (pkt_valid) begin
                pkt_total++;
                if (!pkt.fault) begin
                    assert (pkt.inst == (pkt.pc ^ 32'h5a5a_0000)) else begin
                        err_cnt[0]++;
                        $display("FAIL pkt.inst: got %h expected %h", pkt.inst,
                                 pkt.pc ^ 32'h5a5a_0000);
                    end
                    resident_line[cache_index(pkt.pc)] = pkt.pc / `LINE_BYTES;
                    resident_ok[cache_index(pkt.pc)] = 1'b1;
                end
                assert (pkt.fault == (pkt.pc >= ERR_BASE && pkt.pc <= ERR_END)) else begin
                    err_cnt[4]++;
                    $display("FAIL pkt.fault: got %h for pc %h", pkt.fault, pkt.pc);
                end
                if (expect_target) begin
                    assert (pkt.pc == target_pc) else begin
                        err_cnt[1]++;
                        $display("FAIL pkt.pc: got %h expected target %h", pkt.pc, target_pc);
                    end
                end else if (have_last) begin
                    assert (pkt.pc == last_pc + 32'd4) else begin
                        err_cnt[0]++;
                        $display("FAIL pkt.pc: got %h expected %h", pkt.pc, last_pc + 32'd4);
                    end
                end
                have_last = 1'b1;
                last_pc = pkt.pc;
                expect_target = 1'b0;
            end
            outstanding = outstanding + int'(pkt_valid) - int'(credit_return);
            assert (outstanding <= `FETCH_CREDITS) else begin
                err_cnt[2]++;
                $display("FAIL outstanding: got %h limit %h", outstanding, `FETCH_CREDITS);
            end
            if (arvalid && arready) begin
                idx = cache_index(ar.addr);
                if (ar.addr >= BURST_BASE && ar.addr <= BURST_END) begin
                    assert (ar.len == 8'(`LINE_WORDS - 1) && ar.burst == BURST_INCR
                            && ar.size == 3'd2 && ar.addr % `LINE_BYTES == 0) else begin
                        err_cnt[3]++;
                        $display("FAIL ar: addr %h len %h size %h burst %h", ar.addr, ar.len,
                                 ar.size, ar.burst);
                    end
                end else begin
                    assert (ar.len == 8'd0 && ar.burst == BURST_FIXED && ar.size == 3'd2
                            && ar.addr[1:0] == 2'b00
                            && (ar.addr % `LINE_BYTES == 0 || ar.addr == last_single + 32'd4))
                        else begin
                        err_cnt[3]++;
                        $display("FAIL ar: addr %h len %h size %h burst %h", ar.addr, ar.len,
                                 ar.size, ar.burst);
                    end
                    last_single = ar.addr;
                end
                assert (!(resident_ok[idx] && resident_line[idx] == ar.addr / `LINE_BYTES))
                    else begin
                    err_cnt[5]++;
                    $display("FAIL arvalid: read of resident line at %h", ar.addr);
                end
                resident_ok[idx] = 1'b0; // this slot may now be overwritten by the fill
            end
            if (target_armed) begin
                expect_target = 1'b1;
                target_pc = armed_pc;
                target_armed = 1'b0;
            end
            if (redirect_valid || (cfg_we && cfg_addr == CFG_BOOT_PC)) begin
                target_armed = 1'b1;
                armed_pc = redirect_valid ? redirect_pc : cfg_wdata;
            end
        end
    end

    // decode frees one buffer slot per packet after a random number of cycles
    initial begin
        credit_return = 1'b0;
        rnd = 32'hbdfc;
        forever begin
            @(negedge clk);
            credit_return = 1'b0;
            if (!rst && pkt_total > returns_done) begin
                if (return_wait == 0) begin
                    credit_return = 1'b1;
                    returns_done++;
                    rnd = lcg_next(rnd);
                    return_wait = int'(rnd[18:16]);
                end else begin
                    return_wait--;
                end
            end
        end
    end

    task automatic write_cfg(input cfg_reg_e addr, input logic [31:0] data);
        @(negedge clk);
        cfg_we = 1'b1;
        cfg_addr = addr;
        cfg_wdata = data;
        @(negedge clk);
        cfg_we = 1'b0;
    endtask

    task automatic send_redirect(input logic [31:0] target);
        @(negedge clk);
        redirect_valid = 1'b1;
        redirect_pc = target;
        @(negedge clk);
        redirect_valid = 1'b0;
    endtask

    task automatic wait_packets(input int count);
        int waited;
        waited = 0;
        while (pkt_total < count && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (pkt_total < count) begin
            $display("timed out after %0d cycles waiting for packet %0d", waited, count);
            $display("Test FAILED");
            $finish;
        end
    endtask

    initial begin
        rst = 1'b1;
        cfg_we = 1'b0;
        cfg_addr = CFG_BOOT_PC;
        cfg_wdata = 32'h0;
        redirect_valid = 1'b0;
        redirect_pc = 32'h0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        write_cfg(CFG_BURST_BASE, BURST_BASE);
        write_cfg(CFG_BURST_END, BURST_END);
        write_cfg(CFG_BOOT_PC, BOOT_PC);
        write_cfg(CFG_ENABLE, 32'd1);
        wait_packets(24);               // six lines of single-beat refills
        send_redirect(32'ha000_0280);   // cache slots 8 to 13, burst refills
        wait_packets(48);
        send_redirect(32'ha000_03e0);   // two good lines, then the faulting line
        wait_packets(60);
        send_redirect(32'ha000_0280);   // those lines should all still hit
        wait_packets(84);
        repeat (20) @(posedge clk);
        $display("errors: data %0d target %0d credit %0d request %0d fault %0d refetch %0d",
                 err_cnt[0], err_cnt[1], err_cnt[2], err_cnt[3], err_cnt[4], err_cnt[5]);
        if (err_cnt[0] + err_cnt[1] + err_cnt[2] + err_cnt[3] + err_cnt[4] + err_cnt[5] == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule
